/* apb_seg_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "seg_params.svh"

module apb_seg_regs (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          psel,
    input  wire                          penable,
    input  wire                          pwrite,
    input  wire  [`SEG_ADDR_W-1:0]       paddr,
    input  wire  [`SEG_DATA_W-1:0]       pwdata,
    output logic [`SEG_DATA_W-1:0]       prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         conv_start,
    output seg_reg_pkg::seg_cmd_e        conv_cmd,
    output logic [`SEG_DATA_W-1:0]       conv_value,
    input  wire                          conv_busy,
    input  wire  seg_reg_pkg::seg_digits_t digits,
    output logic                         scan_en,
    output logic [`SEG_DIV_W-1:0]        scan_div
);

    import seg_reg_pkg::*;

    logic                   access;
    logic                   addr_ok;
    logic                   data_busy;
    logic                   wr_ok;
    logic                   data_wr;
    logic [`SEG_DATA_W-1:0] rdata;
    logic                   ctrl_en;
    logic                   ctrl_dec;
    logic [`SEG_DIV_W-1:0]  div_q;

    assign access = psel && penable;    // Access phase.

    // Read mux and address check.
    always_comb begin
        addr_ok = 1'b1;
        rdata   = '0;
        case (paddr)
            `SEG_REG_CTRL:   rdata[1:0] = {ctrl_dec, ctrl_en};
            `SEG_REG_DATA:   rdata = '0;                // Write-only.
            `SEG_REG_DIV:    rdata[`SEG_DIV_W-1:0] = div_q;
            `SEG_REG_STATUS: rdata[0] = conv_busy;
            `SEG_REG_DIGITS: rdata = digits;
            default:         addr_ok = 1'b0;
        endcase
    end

    // A start already queued counts as busy too.
    assign data_busy = pwrite && (paddr == `SEG_REG_DATA) && (conv_busy || conv_start);

    assign pready  = 1'b1;
    assign pslverr = access && (!addr_ok || data_busy);
    assign prdata  = (access && !pwrite) ? rdata : '0;

    assign wr_ok   = access && pwrite && !pslverr;
    assign data_wr = wr_ok && (paddr == `SEG_REG_DATA);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ctrl_en    <= 1'b0;
            ctrl_dec   <= 1'b0;
            div_q      <= `SEG_DIV_W'(`SEG_DIV_RESET);
            conv_start <= 1'b0;
        end else begin
            conv_start <= data_wr;      // One-cycle pulse.
            if (wr_ok && (paddr == `SEG_REG_CTRL)) begin
                ctrl_en  <= pwdata[0];
                ctrl_dec <= pwdata[1];
            end
            if (wr_ok && (paddr == `SEG_REG_DIV)) begin
                div_q <= pwdata[`SEG_DIV_W-1:0];
            end
        end
    end

    // Command follows the mode at the time of the write.
    always_ff @(posedge clk) begin
        if (data_wr) begin
            conv_value <= pwdata;
            conv_cmd   <= ctrl_dec ? CMD_DEC : CMD_HEX;
        end
    end

    assign scan_en  = ctrl_en;
    assign scan_div = div_q;

endmodule

`default_nettype wire

/* digit_convert.sv */
`timescale 1ns/1ns
`default_nettype none

`include "seg_params.svh"

module digit_convert (
    input  wire                            clk,
    input  wire                            rstn,
    input  wire                            conv_start,
    input  wire  seg_reg_pkg::seg_cmd_e    conv_cmd,
    input  wire  [`SEG_DATA_W-1:0]         conv_value,
    output logic                           conv_busy,
    output seg_reg_pkg::seg_digits_t       digits
);

    import seg_reg_pkg::*;
    import seg_disp_pkg::*;

    localparam int BCD_W  = 40;                      // Ten digits cover 32 bits.
    localparam int STEP_W = $clog2(`SEG_DATA_W);

    conv_state_e            state;
    logic [STEP_W-1:0]      step;
    logic [BCD_W-1:0]       bcd_q;
    logic [BCD_W-1:0]       bcd_adj;
    logic [`SEG_DATA_W-1:0] bin_q;
    logic                   load;

    assign load = (state == CONV_IDLE) && conv_start;

    // Add 3 to every digit above 4 before the shift.
    always_comb begin
        bcd_adj = bcd_q;
        for (int i = 0; i < BCD_W / 4; i++) begin
            if (bcd_q[4*i +: 4] > 4'd4) begin
                bcd_adj[4*i +: 4] = bcd_q[4*i +: 4] + 4'd3;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= CONV_IDLE;
            step      <= '0;
            conv_busy <= 1'b0;
            digits    <= '0;
        end else begin
            case (state)
                CONV_IDLE: begin
                    if (conv_start) begin
                        if (conv_cmd == CMD_DEC) begin
                            state     <= CONV_SHIFT;
                            step      <= '0;
                            conv_busy <= 1'b1;
                        end else begin
                            digits <= conv_value;   // Hex goes straight out.
                        end
                    end
                end
                CONV_SHIFT: begin
                    step <= step + 1'b1;
                    if (step == STEP_W'(`SEG_DATA_W - 1)) begin
                        state <= CONV_DONE;
                    end
                end
                CONV_DONE: begin
                    digits    <= bcd_q[4*`SEG_DIGITS-1:0];  // Low eight digits.
                    conv_busy <= 1'b0;
                    state     <= CONV_IDLE;
                end
                default: begin
                    state     <= CONV_IDLE;
                    conv_busy <= 1'b0;
                end
            endcase
        end
    end

    // Working registers.
    always_ff @(posedge clk) begin
        if (load) begin
            bcd_q <= '0;
            bin_q <= conv_value;
        end else if (state == CONV_SHIFT) begin
            bcd_q <= {bcd_adj[BCD_W-2:0], bin_q[`SEG_DATA_W-1]};
            bin_q <= {bin_q[`SEG_DATA_W-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* digit_scan.sv */
`timescale 1ns/1ns
`default_nettype none

`include "seg_params.svh"

module digit_scan (
    input  wire                            clk,
    input  wire                            rstn,
    input  wire                            scan_en,
    input  wire  [`SEG_DIV_W-1:0]          scan_div,
    input  wire  seg_reg_pkg::seg_digits_t digits,
    output logic [`SEG_DIGITS-1:0]         digit_en,
    output seg_disp_pkg::seg_code_t        sseg,
    output seg_disp_pkg::seg_code_t        sseg_hi
);

    import seg_disp_pkg::*;

    logic [`SEG_DIV_W-1:0] dwell_cnt;
    logic [`SEG_DIV_W-1:0] dwell_len;
    logic                  dwell_end;
    digit_sel_t            sel;
    logic [3:0]            nibble;
    seg_code_t             code;
    logic                  hi_bank;

    // Hex to segments, a..g from bit 6 down.
    function automatic seg_code_t seg_encode(input logic [3:0] n);
        case (n)
            4'h0:    return 8'b0111_1110;
            4'h1:    return 8'b0011_0000;
            4'h2:    return 8'b0110_1101;
            4'h3:    return 8'b0111_1001;
            4'h4:    return 8'b0011_0011;
            4'h5:    return 8'b0101_1011;
            4'h6:    return 8'b0101_1111;
            4'h7:    return 8'b0111_0000;
            4'h8:    return 8'b0111_1111;
            4'h9:    return 8'b0111_1011;
            4'hA:    return 8'b0111_0111;
            4'hB:    return 8'b0001_1111;
            4'hC:    return 8'b0100_1110;
            4'hD:    return 8'b0011_1101;
            4'hE:    return 8'b0100_1111;
            4'hF:    return 8'b0100_0111;
            default: return 8'b0000_0000;
        endcase
    endfunction

    assign dwell_end = (dwell_cnt == dwell_len);

    // Dwell length is sampled only when the digit changes.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dwell_cnt <= '0;
            dwell_len <= `SEG_DIV_W'(`SEG_DIV_RESET);
            sel       <= '0;
        end else if (!scan_en) begin
            dwell_cnt <= '0;
            dwell_len <= scan_div;
            sel       <= '0;                        // Held at digit 0.
        end else if (dwell_end) begin
            dwell_cnt <= '0;
            dwell_len <= scan_div;
            sel       <= sel + 1'b1;                // Wraps after 7.
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    assign nibble  = digits[sel*4 +: 4];
    assign code    = seg_encode(nibble);
    assign hi_bank = (sel >= digit_sel_t'(`SEG_DIGITS / 2));

    // Pin registers, one cycle behind the selector.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            digit_en <= '0;
            sseg     <= '0;
            sseg_hi  <= '0;
        end else begin
            digit_en <= scan_en ? (`SEG_DIGITS'(1) << sel) : '0;
            sseg     <= (scan_en && !hi_bank) ? code : '0;
            sseg_hi  <= (scan_en && hi_bank) ? code : '0;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compile with Verilator, run, and pass only if the testbench reports a pass.
verilator --binary --timing --assert -f src.f --top-module tb_seg_display -o tb_seg_display \
    && ./obj_dir/tb_seg_display | tee /dev/stderr \
        | grep "^Simulation finished: PASS$" > /dev/null \
    || { echo "run.sh: simulation failed or did not build" >&2; exit 1; }
echo "run.sh: simulation passed"

/* seg_disp_pkg.sv */
`default_nettype none

`include "seg_params.svh"

package seg_disp_pkg;

    typedef enum logic [1:0] {
        CONV_IDLE  = 2'd0,
        CONV_SHIFT = 2'd1,       // Shift-and-add-3 steps.
        CONV_DONE  = 2'd2        // Commit to the digit register.
    } conv_state_e;

    typedef logic [$clog2(`SEG_DIGITS)-1:0] digit_sel_t;

    // Bit 7 unused, bits 6..0 are segments a..g.
    typedef logic [7:0] seg_code_t;

endpackage

`default_nettype wire

/* seg_display_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

`include "seg_params.svh"

module seg_display_asserts (
    input  wire                              clk,
    input  wire                              rstn,
    input  wire                              scan_en,
    input  wire  seg_disp_pkg::digit_sel_t   sel,
    input  wire  [`SEG_DIGITS-1:0]           digit_en,
    input  wire  seg_disp_pkg::seg_code_t    sseg,
    input  wire  seg_disp_pkg::seg_code_t    sseg_hi,
    input  wire  seg_disp_pkg::conv_state_e  state,
    input  wire                              conv_busy
);

    import seg_disp_pkg::*;

    a_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(digit_en))
        else $error("digit_en is not zero or one-hot: %h", digit_en);

    // Low bank is dark while a high digit is lit, and the other way round.
    a_bank_lo: assert property (@(posedge clk) disable iff (!rstn)
        (digit_en[`SEG_DIGITS-1:`SEG_DIGITS/2] == '0) || (sseg == '0))
        else $error("sseg driven while a high digit is active");
    a_bank_hi: assert property (@(posedge clk) disable iff (!rstn)
        (digit_en[`SEG_DIGITS/2-1:0] == '0) || (sseg_hi == '0))
        else $error("sseg_hi driven while a low digit is active");
    a_blank: assert property (@(posedge clk) disable iff (!rstn)
        (digit_en != '0) || ((sseg == '0) && (sseg_hi == '0)))
        else $error("segments driven with no digit enabled");

    // While scanning the selector only ever moves on by one digit.
    a_sel_step: assert property (@(posedge clk) disable iff (!rstn)
        ($past(scan_en) && (sel != $past(sel)))
            |-> (sel == digit_sel_t'($past(sel) + 1'b1)))
        else $error("selector skipped a digit: %0d", sel);

    a_busy: assert property (@(posedge clk) disable iff (!rstn)
        !(conv_busy && (state == CONV_IDLE)))
        else $error("conv_busy high in CONV_IDLE");

endmodule

// Inputs a block does not have are tied off, so those checks hold trivially there.
bind digit_scan seg_display_asserts u_scan_asserts (
    .clk(clk), .rstn(rstn), .scan_en(scan_en), .sel(sel), .digit_en(digit_en),
    .sseg(sseg), .sseg_hi(sseg_hi), .state(seg_disp_pkg::CONV_IDLE), .conv_busy(1'b0)
);

bind digit_convert seg_display_asserts u_conv_asserts (
    .clk(clk), .rstn(rstn), .scan_en(1'b0), .sel(3'd0), .digit_en(8'h00),
    .sseg(8'h00), .sseg_hi(8'h00), .state(state), .conv_busy(conv_busy)
);

`default_nettype wire

/* seg_display_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "seg_params.svh"

module seg_display_top (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     psel,
    input  wire                     penable,
    input  wire                     pwrite,
    input  wire  [`SEG_ADDR_W-1:0]  paddr,
    input  wire  [`SEG_DATA_W-1:0]  pwdata,
    output logic [`SEG_DATA_W-1:0]  prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic [`SEG_DIGITS-1:0]  digit_en,
    output seg_disp_pkg::seg_code_t sseg,
    output seg_disp_pkg::seg_code_t sseg_hi
);

    import seg_reg_pkg::*;

    logic                   conv_start;
    seg_cmd_e               conv_cmd;
    logic [`SEG_DATA_W-1:0] conv_value;
    logic                   conv_busy;
    seg_digits_t            digits;
    logic                   scan_en;
    logic [`SEG_DIV_W-1:0]  scan_div;

    apb_seg_regs u_decode (
        .clk        (clk),
        .rstn       (rstn),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .conv_start (conv_start),
        .conv_cmd   (conv_cmd),
        .conv_value (conv_value),
        .conv_busy  (conv_busy),
        .digits     (digits),
        .scan_en    (scan_en),
        .scan_div   (scan_div)
    );

    digit_convert u_execute (
        .clk        (clk),
        .rstn       (rstn),
        .conv_start (conv_start),
        .conv_cmd   (conv_cmd),
        .conv_value (conv_value),
        .conv_busy  (conv_busy),
        .digits     (digits)
    );

    digit_scan u_result (
        .clk        (clk),
        .rstn       (rstn),
        .scan_en    (scan_en),
        .scan_div   (scan_div),
        .digits     (digits),
        .digit_en   (digit_en),
        .sseg       (sseg),
        .sseg_hi    (sseg_hi)
    );

endmodule

`default_nettype wire

/* seg_params.svh */
`ifndef SEG_PARAMS_SVH
`define SEG_PARAMS_SVH

// Bus and display geometry.
`define SEG_DATA_W      32
`define SEG_DIGITS      8
`define SEG_ADDR_W      8
`define SEG_DIV_W       16

`define SEG_DIV_RESET   4        // Five cycles per digit.

// APB register offsets.
`define SEG_REG_CTRL    8'h00    // Bit 0 enable, bit 1 decimal.
`define SEG_REG_DATA    8'h04    // Write-only, starts a conversion.
`define SEG_REG_DIV     8'h08
`define SEG_REG_STATUS  8'h0C    // Bit 0 busy.
`define SEG_REG_DIGITS  8'h10    // Read-only, displayed nibbles.

`endif

/* seg_reg_pkg.sv */
`default_nettype none

`include "seg_params.svh"

package seg_reg_pkg;

    // Command sent with each conversion start.
    typedef enum logic {
        CMD_HEX = 1'b0,          // Nibbles copied as they are.
        CMD_DEC = 1'b1           // Binary to BCD.
    } seg_cmd_e;

    // Eight packed digits, digit 0 in the low nibble.
    typedef logic [4*`SEG_DIGITS-1:0] seg_digits_t;

endpackage

`default_nettype wire

/* src.f */
+incdir+.
seg_reg_pkg.sv
seg_disp_pkg.sv
apb_seg_regs.sv
digit_convert.sv
digit_scan.sv
seg_display_top.sv
tb_clock_gen.sv
seg_display_asserts.sv
tb_seg_display.sv

/* tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 rstn = 1'b1;                    // Released with the stimulus offset.
    end

endmodule

`default_nettype wire

/* tb_seg_display.sv */
`timescale 1ns/1ns
`default_nettype none

`include "seg_params.svh"

module tb_seg_display;

    import seg_reg_pkg::*;
    import seg_disp_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int SCAN_DIV    = 2;
    localparam int POLL_LIMIT  = 40;
    localparam int SCAN_STEPS  = 20;
    localparam int T_RESET     = 60;                   // Cycle budgets per test.
    localparam int T_HEX       = 20 * 20;
    localparam int T_DEC       = 24 * 60;
    localparam int T_SCAN      = 60 + SCAN_STEPS * (SCAN_DIV + 1);
    localparam int T_ERR       = 150;
    localparam int WATCHDOG_NS = (T_RESET + T_HEX + T_DEC + T_SCAN + T_ERR + 500) * CLK_PERIOD;

    // Segments a..g in bits 6..0.
    localparam seg_code_t SEG_TABLE [16] = '{
        8'h7E, 8'h30, 8'h6D, 8'h79, 8'h33, 8'h5B, 8'h5F, 8'h70,
        8'h7F, 8'h7B, 8'h77, 8'h1F, 8'h4E, 8'h3D, 8'h4F, 8'h47
    };

    logic                   clk;
    logic                   rstn;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`SEG_ADDR_W-1:0] paddr;
    logic [`SEG_DATA_W-1:0] pwdata;
    logic [`SEG_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
    logic [`SEG_DIGITS-1:0] digit_en;
    seg_code_t              sseg;
    seg_code_t              sseg_hi;
    logic [31:0]            lfsr_state;
    int                     checks;
    int                     errors;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(2)) u_clk (.clk(clk), .rstn(rstn));

    seg_display_top DUT (.*);

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        for (int i = 0; i < 32; i++) w[i] = lfsr_bit();
        return w;
    endfunction

    // Low eight decimal digits of the value.
    function automatic seg_digits_t dec_model(input logic [31:0] v);
        seg_digits_t d;
        logic [31:0] r;
        r = v % 32'd100_000_000;
        for (int i = 0; i < 8; i++) begin
            d[4*i +: 4] = 4'(r % 32'd10);
            r = r / 32'd10;
        end
        return d;
    endfunction

    task automatic check_digits(input string name, input seg_digits_t got, input seg_digits_t exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_seg(input string name, input seg_code_t got, input seg_code_t exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Setup cycle, access cycle, response sampled mid-cycle.
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #10;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #10;
        penable = 1'b1;
        @(negedge clk);
        check_bit("pready", pready, 1'b1);     // No wait states.
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_xfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic wait_idle(input logic busy_first);
        logic [31:0] rd;
        logic        err;
        int          polls;
        polls = 0;
        rd    = 32'h1;
        while (rd[0] && polls < POLL_LIMIT) begin
            apb_read(`SEG_REG_STATUS, rd, err);
            if (polls == 0) check_bit("STATUS.busy", rd[0], busy_first);
            polls++;
        end
        if (rd[0]) begin
            $display("ERROR: converter still busy after %0d status reads", polls);
            errors++;
        end
    endtask

    task automatic convert_and_check(input logic [31:0] v, input seg_digits_t exp, input logic dec);
        logic [31:0] rd;
        logic        err;
        apb_write(`SEG_REG_DATA, v, err);
        check_bit("pslverr", err, 1'b0);
        wait_idle(dec);
        apb_read(`SEG_REG_DIGITS, rd, err);
        check_digits("DIGITS", rd, exp);
    endtask

    task automatic test_reset();
        logic [31:0] rd;
        logic        err;
        apb_read(`SEG_REG_CTRL, rd, err);
        check_word("CTRL", rd, 32'h0);
        apb_read(`SEG_REG_DIV, rd, err);
        check_word("DIV", rd, 32'(`SEG_DIV_RESET));
        apb_read(`SEG_REG_DIGITS, rd, err);
        check_digits("DIGITS", rd, '0);
        apb_read(`SEG_REG_STATUS, rd, err);
        check_word("STATUS", rd, 32'h0);
        repeat (8) begin
            @(negedge clk);
            check_word("digit_en", 32'(digit_en), 32'h0);
        end
    endtask

    task automatic test_hex();
        logic [31:0] v;
        logic        err;
        apb_write(`SEG_REG_CTRL, 32'h0, err);
        repeat (20) begin
            v = rand_word();
            convert_and_check(v, v, 1'b0);
        end
    endtask

    task automatic test_dec();
        logic [31:0] vals[$];
        logic        err;
        apb_write(`SEG_REG_CTRL, 32'h2, err);
        repeat (20) vals.push_back(rand_word());
        vals.push_back(32'd0);
        vals.push_back(32'd99_999_999);
        vals.push_back(32'd100_000_000);
        vals.push_back(32'hFFFF_FFFF);
        foreach (vals[i]) convert_and_check(vals[i], dec_model(vals[i]), 1'b1);
    endtask

    // Follows digit_en through a number of digit changes.
    task automatic scan_check(input seg_digits_t shown, input int steps);
        logic [`SEG_DIGITS-1:0] prev_en;
        int                     prev_idx;
        int                     idx;
        int                     cycles;
        seg_code_t              exp_code;
        @(negedge clk);
        prev_en  = digit_en;
        prev_idx = -1;                      // First lit digit must be 0.
        for (int n = 0; n < steps; n++) begin
            cycles = 0;
            while (digit_en === prev_en && cycles < 4 * (SCAN_DIV + 2)) begin
                @(negedge clk);
                cycles++;
            end
            if (digit_en === prev_en) begin
                $display("ERROR: digit_en did not change within %0d cycles", cycles);
                errors++;
                return;
            end
            check_bit("digit_en one-hot", $onehot(digit_en), 1'b1);
            idx = 0;
            for (int i = 0; i < `SEG_DIGITS; i++) if (digit_en[i]) idx = i;
            check_word("digit index", 32'(idx), 32'((prev_idx + 1) % `SEG_DIGITS));
            if (prev_idx >= 0) check_word("dwell cycles", 32'(cycles), 32'(SCAN_DIV + 1));
            exp_code = SEG_TABLE[shown[4*idx +: 4]];
            if (idx < `SEG_DIGITS / 2) begin
                check_seg("sseg", sseg, exp_code);
                check_seg("sseg_hi", sseg_hi, 8'h00);
            end else begin
                check_seg("sseg", sseg, 8'h00);
                check_seg("sseg_hi", sseg_hi, exp_code);
            end
            prev_en  = digit_en;
            prev_idx = idx;
        end
    endtask

    task automatic test_scan();
        logic [31:0] v;
        logic        err;
        v = rand_word();
        apb_write(`SEG_REG_CTRL, 32'h0, err);
        convert_and_check(v, v, 1'b0);
        apb_write(`SEG_REG_DIV, 32'(SCAN_DIV), err);
        apb_write(`SEG_REG_CTRL, 32'h1, err);
        scan_check(v, SCAN_STEPS);
        apb_write(`SEG_REG_CTRL, 32'h0, err);
        repeat (2) @(negedge clk);
        check_word("digit_en", 32'(digit_en), 32'h0);
    endtask

    task automatic test_errors();
        logic [31:0] v0;
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] rd;
        logic        err;
        v0 = rand_word();
        v1 = rand_word();
        v2 = rand_word();
        apb_write(`SEG_REG_CTRL, 32'h0, err);
        convert_and_check(v0, v0, 1'b0);    // Known value on the display.
        apb_write(`SEG_REG_CTRL, 32'h2, err);
        apb_write(`SEG_REG_DATA, v1, err);
        check_bit("pslverr", err, 1'b0);
        apb_write(`SEG_REG_DATA, v2, err);  // Rejected, converter busy.
        check_bit("pslverr", err, 1'b1);
        apb_read(`SEG_REG_DIGITS, rd, err);
        check_digits("DIGITS", rd, v0);
        wait_idle(1'b1);
        apb_read(`SEG_REG_DIGITS, rd, err);
        check_digits("DIGITS", rd, dec_model(v1));
        apb_read(8'h14, rd, err);
        check_bit("pslverr", err, 1'b1);
        apb_write(8'h20, 32'h1, err);
        check_bit("pslverr", err, 1'b1);
    endtask

    initial begin
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        lfsr_state = 32'h9c61;
        checks     = 0;
        errors     = 0;
        @(posedge rstn);
        test_reset();
        test_hex();
        test_dec();
        test_scan();
        test_errors();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
        $display("Checks run: %0d, errors: %0d", checks, errors + 1);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
